// File: dm_regs.f
+incdir+verilog
verilog/dm_pkg.sv
verilog/dm_hart_ctrl.sv
verilog/dm_abstract_cmd.sv
verilog/dm_resp_queue.sv
verilog/dm_regs_top.sv
bench/tb_dm_regs.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_dm_regs
FILELIST  ?= dm_regs.f
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   lint, build and run the testbench with Verilator"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR) -o $(TOP)
	./$(OBJDIR)/$(TOP)

clean:
	rm -rf $(OBJDIR)

// File: bench/tb_dm_regs.sv
`timescale 1ns/1ns
`include "dm_settings.svh"

module tb_dm_regs;

  logic clk_i, rst_ni, dmi_rst_ni, dmi_req_valid_i, dmi_req_ready_o;
  logic dmi_resp_valid_o, dmi_resp_ready_i, ndmreset_o, dmactive_o;
  logic halted_i, unavailable_i, resumeack_i, haltreq_o, resumereq_o, clear_resumeack_o;
  logic cmd_valid_o, cmderror_valid_i, cmdbusy_i, data_valid_i;
  logic [19:0] hartsel_o;
  logic [`DM_WORD_W-1:0] cmd_o;
  logic [`DM_CMDERR_W-1:0] cmderror_i;
  logic [`DM_PROGBUF_SIZE-1:0][`DM_WORD_W-1:0] progbuf_o;
  logic [`DM_DATA_COUNT-1:0][`DM_WORD_W-1:0] data_o, data_i;
  dm_pkg::dmi_req_t  dmi_req_i;
  dm_pkg::dmi_resp_t dmi_resp_o, rsp;
  int seed = 32'h1c27;
  int cmd_pulses, clr_pulses, i;
  logic [31:0] w, ref_words[10], exp_cs;

  dm_regs_top DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // pulse counters, sampled mid-cycle
  always @(negedge clk_i) begin
    if (cmd_valid_o) cmd_pulses <= cmd_pulses + 1;
    if (clear_resumeack_o) clr_pulses <= clr_pulses + 1;
  end

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      $display("FAIL %s expected %h actual %h", name, exp, act);
      $display(">>> FAIL");
      $fatal(1);
    end
  endtask

  task automatic time_out(input string what);
    $display("timeout while waiting for %s", what);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  // one request, then wait for its response
  task automatic dmi_access(input logic [1:0] op, input logic [6:0] addr, input logic [31:0] d);
    int t;
    @(posedge clk_i);
    dmi_req_valid_i <= 1'b1;
    dmi_req_i       <= '{addr: addr, data: d, op: op};
    t = 0;
    @(negedge clk_i);
    while (!dmi_req_ready_o) begin
      t++;
      if (t > 100) time_out("request ready");
      @(negedge clk_i);
    end
    @(posedge clk_i);
    dmi_req_valid_i <= 1'b0;
    t = 0;
    @(negedge clk_i);
    while (!dmi_resp_valid_o) begin
      t++;
      if (t > 100) time_out("response valid");
      @(negedge clk_i);
    end
    rsp = dmi_resp_o;
    repeat (2) @(negedge clk_i);  // let pulse counters settle
  endtask

  // reference dmstatus from the hart inputs
  function automatic logic [31:0] dmstatus_ref(input logic halted, input logic unavail,
                                               input logic ack, input logic hrst,
                                               input logic sel_nz);
    logic [31:0] s;
    s = 32'h0000_0082;
    s[9:8]   = {2{halted && !unavail}};
    s[11:10] = {2{!halted && !unavail}};
    s[13:12] = {2{unavail}};
    s[15:14] = {2{sel_nz}};
    s[17:16] = {2{ack}};
    s[19:18] = {2{hrst}};
    return s;
  endfunction

  initial begin
    {dmi_req_valid_i, halted_i, unavailable_i, resumeack_i, cmderror_valid_i} = '0;
    {cmdbusy_i, data_valid_i, cmderror_i} = '0;
    dmi_req_i = '0;
    data_i = '0;
    dmi_resp_ready_i = 1'b1;
    dmi_rst_ni = 1'b1;
    cmd_pulses = 0;
    clr_pulses = 0;
    rst_ni = 1'b0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    dmi_access(`DM_OP_READ, `DM_ADDR_DMSTATUS, 0);
    check_eq("dmstatus_reset", dmstatus_ref(0, 0, 0, 1, 0), rsp.data);
    w = $random(seed);
    dmi_access(`DM_OP_WRITE, `DM_ADDR_DMCONTROL, w & 32'hEFFF_FFFE);
    dmi_access(`DM_OP_READ, `DM_ADDR_DMCONTROL, 0);
    check_eq("dmcontrol_inactive", 0, rsp.data);
    dmi_access(`DM_OP_WRITE, `DM_ADDR_DMCONTROL, 32'h1);
    check_eq("dmactive_o", 1, 32'(dmactive_o));
    w = ($random(seed) & 32'hAFFF_FFFD) | 32'h8000_0001;  // haltreq, no resumereq/ndmreset/ack
    dmi_access(`DM_OP_WRITE, `DM_ADDR_DMCONTROL, w);
    dmi_access(`DM_OP_READ, `DM_ADDR_DMCONTROL, 0);
    check_eq("dmcontrol_rand", w & 32'hC3FF_FFC3, rsp.data);
    check_eq("hartsel_o", 32'({w[15:6], w[25:16]}), 32'(hartsel_o));
    check_eq("haltreq_sel", 32'(w[31] && (w[25:6] == 0)), 32'(haltreq_o));
    dmi_access(`DM_OP_WRITE, `DM_ADDR_DMCONTROL, 32'h1000_0001);  // ackhavereset
    dmi_access(`DM_OP_READ, `DM_ADDR_DMSTATUS, 0);
    check_eq("havereset_ack", dmstatus_ref(0, 0, 0, 0, 0), rsp.data);
    dmi_access(`DM_OP_WRITE, `DM_ADDR_DMCONTROL, 32'h3);
    check_eq("ndmreset_o", 1, 32'(ndmreset_o));
    dmi_access(`DM_OP_WRITE, `DM_ADDR_DMCONTROL, 32'h1);
    check_eq("ndmreset_clr", 0, 32'(ndmreset_o));
    dmi_access(`DM_OP_READ, `DM_ADDR_DMSTATUS, 0);
    check_eq("havereset_ndm", dmstatus_ref(0, 0, 0, 1, 0), rsp.data);
    dmi_access(`DM_OP_WRITE, `DM_ADDR_DMCONTROL, 32'h8000_0001);
    check_eq("haltreq_o", 1, 32'(haltreq_o));
    i = clr_pulses;
    dmi_access(`DM_OP_WRITE, `DM_ADDR_DMCONTROL, 32'h4000_0001);
    check_eq("clear_resumeack", i + 1, clr_pulses);
    check_eq("resumereq_o", 1, 32'(resumereq_o));
    @(posedge clk_i) resumeack_i <= 1'b1;
    repeat (2) @(posedge clk_i);
    resumeack_i <= 1'b0;
    @(negedge clk_i);
    check_eq("resumereq_ack", 0, 32'(resumereq_o));
    @(posedge clk_i) halted_i <= 1'b1;
    dmi_access(`DM_OP_READ, `DM_ADDR_DMSTATUS, 0);
    check_eq("dmstatus_halted", dmstatus_ref(1, 0, 0, 1, 0), rsp.data);
    dmi_access(`DM_OP_READ, `DM_ADDR_HALTSUM0, 0);
    check_eq("haltsum0", 1, rsp.data);
    @(posedge clk_i) unavailable_i <= 1'b1;
    dmi_access(`DM_OP_READ, `DM_ADDR_DMSTATUS, 0);
    check_eq("dmstatus_unavail", dmstatus_ref(1, 1, 0, 1, 0), rsp.data);
    w = $random(seed);
    i = cmd_pulses;
    dmi_access(`DM_OP_WRITE, `DM_ADDR_COMMAND, w);
    check_eq("cmd_pulse", i + 1, cmd_pulses);
    check_eq("cmd_o", w, cmd_o);
    @(posedge clk_i) cmdbusy_i <= 1'b1;
    dmi_access(`DM_OP_WRITE, `DM_ADDR_COMMAND, 0);
    check_eq("cmd_busy_resp", 32'(`DM_RESP_BUSY), 32'(rsp.resp));
    exp_cs = 32'h0800_0002 | (32'h1 << 12) | (32'h1 << 8);
    dmi_access(`DM_OP_READ, `DM_ADDR_ABSTRACTCS, 0);
    check_eq("abstractcs_busy", exp_cs, rsp.data);
    @(posedge clk_i) cmdbusy_i <= 1'b0;
    dmi_access(`DM_OP_WRITE, `DM_ADDR_ABSTRACTCS, 32'h700);
    dmi_access(`DM_OP_READ, `DM_ADDR_ABSTRACTCS, 0);
    check_eq("cmderr_w1c", 32'h0800_0002, rsp.data);
    @(posedge clk_i);
    cmderror_valid_i <= 1'b1;
    cmderror_i       <= 3'd3;
    @(posedge clk_i) cmderror_valid_i <= 1'b0;
    dmi_access(`DM_OP_READ, `DM_ADDR_ABSTRACTCS, 0);
    check_eq("cmderr_load", 32'h0800_0302, rsp.data);
    for (i = 0; i < 10; i++) begin
      ref_words[i] = $random(seed);
      dmi_access(`DM_OP_WRITE, (i < 2) ? 7'(`DM_ADDR_DATA0 + i) :
                 7'(`DM_ADDR_PROGBUF0 + i - 2), ref_words[i]);
    end
    for (i = 0; i < 10; i++) begin
      dmi_access(`DM_OP_READ, (i < 2) ? 7'(`DM_ADDR_DATA0 + i) :
                 7'(`DM_ADDR_PROGBUF0 + i - 2), 0);
      check_eq($sformatf("word_%0d", i), ref_words[i], rsp.data);
      check_eq($sformatf("word_port_%0d", i), ref_words[i],
               (i < 2) ? data_o[i] : progbuf_o[i - 2]);
    end
    dmi_access(`DM_OP_WRITE, `DM_ADDR_ABSTRACTAUTO, 32'h0002_0001);
    dmi_access(`DM_OP_READ, `DM_ADDR_ABSTRACTAUTO, 0);
    check_eq("abstractauto", 32'h0002_0001, rsp.data);
    i = cmd_pulses;
    dmi_access(`DM_OP_READ, `DM_ADDR_DATA0, 0);
    dmi_access(`DM_OP_WRITE, 7'(`DM_ADDR_PROGBUF0 + 1), 0);
    check_eq("autoexec", i + 2, cmd_pulses);
    dmi_access(`DM_OP_WRITE, `DM_ADDR_ABSTRACTAUTO, 0);
    @(posedge clk_i);
    data_i[0] <= $random(seed);
    data_i[1] <= $random(seed);
    data_valid_i <= 1'b1;
    @(posedge clk_i) data_valid_i <= 1'b0;
    dmi_access(`DM_OP_READ, 7'(`DM_ADDR_DATA0 + 1), 0);
    check_eq("data_load", data_i[1], rsp.data);
    // two reads held while the host stalls
    @(posedge clk_i);
    dmi_resp_ready_i <= 1'b0;
    dmi_req_valid_i  <= 1'b1;
    dmi_req_i        <= '{addr: `DM_ADDR_DATA0, data: 0, op: `DM_OP_READ};
    @(negedge clk_i) check_eq("bp_ready0", 1, 32'(dmi_req_ready_o));
    @(posedge clk_i) dmi_req_i <= '{addr: `DM_ADDR_PROGBUF0, data: 0, op: `DM_OP_READ};
    @(negedge clk_i) check_eq("bp_ready1", 1, 32'(dmi_req_ready_o));
    @(posedge clk_i) dmi_req_valid_i <= 1'b0;
    @(negedge clk_i) check_eq("bp_full", 0, 32'(dmi_req_ready_o));
    @(posedge clk_i) dmi_resp_ready_i <= 1'b1;
    @(negedge clk_i) check_eq("bp_first", data_i[0], dmi_resp_o.data);
    @(negedge clk_i) check_eq("bp_second", ref_words[2], dmi_resp_o.data);
    @(negedge clk_i) check_eq("bp_empty", 0, 32'(dmi_resp_valid_o));
    $display(">>> PASS");
    $finish;
  end

endmodule

// File: verilog/dm_regs_top.sv
`timescale 1ns/1ns
`include "dm_settings.svh"

module dm_regs_top (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  logic                                        dmi_rst_ni,
  input  logic                                        dmi_req_valid_i,
  output logic                                        dmi_req_ready_o,
  input  dm_pkg::dmi_req_t                            dmi_req_i,
  output logic                                        dmi_resp_valid_o,
  input  logic                                        dmi_resp_ready_i,
  output dm_pkg::dmi_resp_t                           dmi_resp_o,
  output logic                                        ndmreset_o,
  output logic                                        dmactive_o,
  input  logic                                        halted_i,
  input  logic                                        unavailable_i,
  input  logic                                        resumeack_i,
  output logic [19:0]                                 hartsel_o,
  output logic                                        haltreq_o,
  output logic                                        resumereq_o,
  output logic                                        clear_resumeack_o,
  output logic                                        cmd_valid_o,
  output logic [`DM_WORD_W-1:0]                       cmd_o,
  input  logic                                        cmderror_valid_i,
  input  logic [`DM_CMDERR_W-1:0]                     cmderror_i,
  input  logic                                        cmdbusy_i,
  output logic [`DM_PROGBUF_SIZE-1:0][`DM_WORD_W-1:0] progbuf_o,
  output logic [`DM_DATA_COUNT-1:0][`DM_WORD_W-1:0]   data_o,
  input  logic [`DM_DATA_COUNT-1:0][`DM_WORD_W-1:0]   data_i,
  input  logic                                        data_valid_i
);

  logic             req_accept;  // request taken this cycle
  dm_pkg::csr_rsp_t hart_rsp, abs_rsp;

  dm_hart_ctrl u_hart_ctrl (
    .clk_i, .rst_ni, .req_accept_i(req_accept), .req_i(dmi_req_i),
    .halted_i, .unavailable_i, .resumeack_i, .rsp_o(hart_rsp),
    .dmactive_o, .ndmreset_o, .hartsel_o, .haltreq_o, .resumereq_o, .clear_resumeack_o
  );

  dm_abstract_cmd u_abstract_cmd (
    .clk_i, .rst_ni, .req_accept_i(req_accept), .req_i(dmi_req_i),
    .dmactive_i(dmactive_o), .cmdbusy_i, .cmderror_valid_i, .cmderror_i,
    .data_valid_i, .data_i, .rsp_o(abs_rsp), .cmd_valid_o, .cmd_o, .data_o, .progbuf_o
  );

  dm_resp_queue u_resp_queue (
    .clk_i, .rst_ni, .dmi_rst_ni, .req_valid_i(dmi_req_valid_i),
    .req_ready_o(dmi_req_ready_o), .req_accept_o(req_accept),
    .hart_rsp_i(hart_rsp), .abs_rsp_i(abs_rsp), .resp_valid_o(dmi_resp_valid_o),
    .resp_ready_i(dmi_resp_ready_i), .resp_o(dmi_resp_o)
  );

endmodule

// File: verilog/dm_resp_queue.sv
`timescale 1ns/1ns
`include "dm_settings.svh"

module dm_resp_queue (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              dmi_rst_ni,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  output logic              req_accept_o,
  input  dm_pkg::csr_rsp_t  hart_rsp_i,
  input  dm_pkg::csr_rsp_t  abs_rsp_i,
  output logic              resp_valid_o,
  input  logic              resp_ready_i,
  output dm_pkg::dmi_resp_t resp_o
);

  dm_pkg::dmi_resp_t mem [2];
  dm_pkg::dmi_resp_t merged;
  logic              wr_ptr, rd_ptr;
  logic [1:0]        count;  // 0..2 entries
  logic              push, pop;

  assign req_ready_o  = (count != 2'd2);
  assign req_accept_o = req_valid_i && req_ready_o;
  assign push         = req_accept_o;
  assign resp_valid_o = (count != 2'd0);
  assign pop          = resp_valid_o && resp_ready_i;
  assign resp_o       = mem[rd_ptr];

  // only one side claims a given address
  always_comb begin
    if (abs_rsp_i.busy)
      merged.resp = `DM_RESP_BUSY;
    else
      merged.resp = `DM_RESP_SUCCESS;
    if (hart_rsp_i.hit)
      merged.data = hart_rsp_i.rdata;
    else if (abs_rsp_i.hit)
      merged.data = abs_rsp_i.rdata;
    else
      merged.data = '0;  // unmapped address
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else if (!dmi_rst_ni) begin
      wr_ptr <= 1'b0;  // host side flush
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (push)
        wr_ptr <= ~wr_ptr;
      if (pop)
        rd_ptr <= ~rd_ptr;
      count <= count + {1'b0, push} - {1'b0, pop};
    end
  end

  always_ff @(posedge clk_i) begin
    if (push)
      mem[wr_ptr] <= merged;
  end

endmodule

// File: verilog/dm_abstract_cmd.sv
`timescale 1ns/1ns
`include "dm_settings.svh"

module dm_abstract_cmd (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  logic                                        req_accept_i,
  input  dm_pkg::dmi_req_t                            req_i,
  input  logic                                        dmactive_i,
  input  logic                                        cmdbusy_i,
  input  logic                                        cmderror_valid_i,
  input  logic [`DM_CMDERR_W-1:0]                     cmderror_i,
  input  logic                                        data_valid_i,
  input  logic [`DM_DATA_COUNT-1:0][`DM_WORD_W-1:0]   data_i,
  output dm_pkg::csr_rsp_t                            rsp_o,
  output logic                                        cmd_valid_o,
  output logic [`DM_WORD_W-1:0]                       cmd_o,
  output logic [`DM_DATA_COUNT-1:0][`DM_WORD_W-1:0]   data_o,
  output logic [`DM_PROGBUF_SIZE-1:0][`DM_WORD_W-1:0] progbuf_o
);

  localparam int data_idx_w = $clog2(`DM_DATA_COUNT);
  localparam int pbuf_idx_w = $clog2(`DM_PROGBUF_SIZE);
  localparam int dcnt_w     = `DM_DATACOUNT_W;
  localparam int pbsz_w     = `DM_PROGBUFSIZE_W;

  logic [`DM_DATA_COUNT-1:0][`DM_WORD_W-1:0]   data_q, data_d;
  logic [`DM_PROGBUF_SIZE-1:0][`DM_WORD_W-1:0] progbuf_q, progbuf_d;
  logic [`DM_WORD_W-1:0]       command_q, command_d;
  logic [`DM_CMDERR_W-1:0]     cmderr_q, cmderr_d;
  logic [`DM_DATA_COUNT-1:0]   autoexecdata_q, autoexecdata_d;
  logic [`DM_PROGBUF_SIZE-1:0] autoexecprogbuf_q, autoexecprogbuf_d;
  logic                        cmd_valid_q, cmd_valid_d;
  dm_pkg::csr_word_u           wdata, abscs;
  logic [`DM_WORD_W-1:0]       auto_word;
  logic [`DM_ADDR_W-1:0]       data_off, pbuf_off;
  logic [data_idx_w-1:0]       data_idx;
  logic [pbuf_idx_w-1:0]       pbuf_idx;
  logic                        rd, wr, busy_acc;
  logic                        is_data, is_pbuf, is_abscs, is_cmd, is_auto;

  assign wdata    = req_i.data;
  assign rd       = req_accept_i && dmactive_i && (req_i.op == `DM_OP_READ);
  assign wr       = req_accept_i && dmactive_i && (req_i.op == `DM_OP_WRITE);
  assign data_off = req_i.addr - `DM_ADDR_DATA0;
  assign pbuf_off = req_i.addr - `DM_ADDR_PROGBUF0;
  assign data_idx = data_off[data_idx_w-1:0];
  assign pbuf_idx = pbuf_off[pbuf_idx_w-1:0];
  assign is_data  = (req_i.addr >= `DM_ADDR_DATA0) && (int'(data_off) < `DM_DATA_COUNT);
  assign is_pbuf  = (req_i.addr >= `DM_ADDR_PROGBUF0) &&
                    (int'(pbuf_off) < `DM_PROGBUF_SIZE);
  assign is_abscs = (req_i.addr == `DM_ADDR_ABSTRACTCS);
  assign is_cmd   = (req_i.addr == `DM_ADDR_COMMAND);
  assign is_auto  = (req_i.addr == `DM_ADDR_ABSTRACTAUTO);

  // accesses refused while the hart runs a command
  assign busy_acc = cmdbusy_i &&
                    ((wr && (is_cmd || is_auto || is_data || is_pbuf || is_abscs)) ||
                     (rd && (is_data || is_pbuf)));

  always_comb begin
    data_d            = data_q;
    progbuf_d         = progbuf_q;
    command_d         = command_q;
    cmderr_d          = cmderr_q;
    autoexecdata_d    = autoexecdata_q;
    autoexecprogbuf_d = autoexecprogbuf_q;
    cmd_valid_d       = 1'b0;
    if (busy_acc) begin
      if (cmderr_q == `DM_CMDERR_NONE)
        cmderr_d = `DM_CMDERR_BUSY;  // keep the first error
    end else if (is_data && (rd || wr)) begin
      cmd_valid_d = autoexecdata_q[data_idx];
      if (wr)
        data_d[data_idx] = wdata.raw;
    end else if (is_pbuf && (rd || wr)) begin
      cmd_valid_d = autoexecprogbuf_q[pbuf_idx];
      if (wr)
        progbuf_d[pbuf_idx] = wdata.raw;
    end else if (wr && is_cmd) begin
      command_d   = wdata.raw;
      cmd_valid_d = 1'b1;
    end else if (wr && is_auto) begin
      autoexecdata_d    = wdata.raw[`DM_DATA_COUNT-1:0];
      autoexecprogbuf_d = wdata.raw[16 +: `DM_PROGBUF_SIZE];
    end else if (wr && is_abscs) begin
      cmderr_d = cmderr_q & ~wdata.abstractcs.cmderr;  // w1c
    end
    if (cmderror_valid_i)
      cmderr_d = cmderror_i;
    if (data_valid_i)
      data_d = data_i;  // hart writes back data0..n
    if (!dmactive_i) begin
      data_d            = '0;
      progbuf_d         = '0;
      command_d         = '0;
      cmderr_d          = `DM_CMDERR_NONE;
      autoexecdata_d    = '0;
      autoexecprogbuf_d = '0;
      cmd_valid_d       = 1'b0;
    end
  end

  always_comb begin
    abscs                        = '0;
    abscs.abstractcs.datacount   = dcnt_w'(`DM_DATA_COUNT);
    abscs.abstractcs.progbufsize = pbsz_w'(`DM_PROGBUF_SIZE);
    abscs.abstractcs.busy        = cmdbusy_i;
    abscs.abstractcs.cmderr      = cmderr_q;
    auto_word                            = '0;
    auto_word[`DM_DATA_COUNT-1:0]        = autoexecdata_q;
    auto_word[16 +: `DM_PROGBUF_SIZE]    = autoexecprogbuf_q;
  end

  always_comb begin
    rsp_o      = '0;
    rsp_o.busy = busy_acc;
    if (rd) begin
      rsp_o.hit = is_data || is_pbuf || is_abscs || is_cmd || is_auto;
      if (is_data)
        rsp_o.rdata = data_q[data_idx];
      else if (is_pbuf)
        rsp_o.rdata = progbuf_q[pbuf_idx];
      else if (is_abscs)
        rsp_o.rdata = abscs.raw;
      else if (is_auto)
        rsp_o.rdata = auto_word;  // command itself reads as zero
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmderr_q          <= `DM_CMDERR_NONE;
      cmd_valid_q       <= 1'b0;
      autoexecdata_q    <= '0;
      autoexecprogbuf_q <= '0;
    end else begin
      cmderr_q          <= cmderr_d;
      cmd_valid_q       <= cmd_valid_d;
      autoexecdata_q    <= autoexecdata_d;
      autoexecprogbuf_q <= autoexecprogbuf_d;
    end
  end

  always_ff @(posedge clk_i) begin
    data_q    <= data_d;
    progbuf_q <= progbuf_d;
    command_q <= command_d;
  end

  assign cmd_valid_o = cmd_valid_q;
  assign cmd_o       = command_q;
  assign data_o      = data_q;
  assign progbuf_o   = progbuf_q;

endmodule

// File: verilog/dm_hart_ctrl.sv
`timescale 1ns/1ns
`include "dm_settings.svh"

module dm_hart_ctrl (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               req_accept_i,
  input  dm_pkg::dmi_req_t   req_i,
  input  logic               halted_i,
  input  logic               unavailable_i,
  input  logic               resumeack_i,
  output dm_pkg::csr_rsp_t   rsp_o,
  output logic               dmactive_o,
  output logic               ndmreset_o,
  output logic [19:0]        hartsel_o,
  output logic               haltreq_o,
  output logic               resumereq_o,
  output logic               clear_resumeack_o
);

  dm_pkg::dmcontrol_t    dmcontrol_q, dmcontrol_d;
  dm_pkg::csr_word_u     wdata;
  logic                  havereset_q, havereset_d;
  logic                  rd, wr_dmcontrol;
  logic [`DM_WORD_W-1:0] dmstatus;

  assign wdata        = req_i.data;
  assign rd           = req_accept_i && (req_i.op == `DM_OP_READ);
  assign wr_dmcontrol = req_accept_i && (req_i.op == `DM_OP_WRITE) &&
                        (req_i.addr == `DM_ADDR_DMCONTROL);

  always_comb begin
    dmcontrol_d = dmcontrol_q;
    if (wr_dmcontrol) begin
      dmcontrol_d              = wdata.dmcontrol;
      dmcontrol_d.hartreset    = 1'b0;
      dmcontrol_d.ackhavereset = 1'b0;  // write-only strobe
      dmcontrol_d.hasel        = 1'b0;  // single hart
      dmcontrol_d.zero1        = 1'b0;
      dmcontrol_d.zero0        = '0;
    end
    if (dmcontrol_q.resumereq && resumeack_i)
      dmcontrol_d.resumereq = 1'b0;  // hart took the resume
    // inactive module: only dmactive is writable
    if (!dmcontrol_q.dmactive) begin
      dmcontrol_d          = '0;
      dmcontrol_d.dmactive = wr_dmcontrol && wdata.dmcontrol.dmactive;
    end
  end

  always_comb begin
    havereset_d = havereset_q;
    if (wr_dmcontrol && wdata.dmcontrol.ackhavereset)
      havereset_d = 1'b0;
    if (ndmreset_o)
      havereset_d = 1'b1;  // set wins over ack
  end

  assign clear_resumeack_o = !dmcontrol_q.resumereq && dmcontrol_d.resumereq;
  assign hartsel_o   = {dmcontrol_q.hartselhi, dmcontrol_q.hartsello};
  assign haltreq_o   = dmcontrol_q.haltreq && (hartsel_o == '0);
  assign resumereq_o = dmcontrol_q.resumereq && (hartsel_o == '0);
  assign dmactive_o  = dmcontrol_q.dmactive;
  assign ndmreset_o  = dmcontrol_q.ndmreset;

  always_comb begin
    dmstatus        = '0;
    dmstatus[3:0]   = 4'd2;                                 // spec 0.13
    dmstatus[7]     = 1'b1;                                 // authenticated
    dmstatus[9:8]   = {2{halted_i & ~unavailable_i}};
    dmstatus[11:10] = {2{~halted_i & ~unavailable_i}};
    dmstatus[13:12] = {2{unavailable_i}};
    dmstatus[15:14] = {2{hartsel_o != '0}};                 // only hart 0 exists
    dmstatus[17:16] = {2{resumeack_i}};
    dmstatus[19:18] = {2{havereset_q}};
  end

  always_comb begin
    rsp_o = '0;
    if (rd) begin
      if (req_i.addr == `DM_ADDR_DMCONTROL) begin
        rsp_o.hit   = 1'b1;
        rsp_o.rdata = dmcontrol_q;
      end else if (req_i.addr == `DM_ADDR_DMSTATUS) begin
        rsp_o.hit   = 1'b1;
        rsp_o.rdata = dmstatus;
      end else if (req_i.addr == `DM_ADDR_HALTSUM0) begin
        rsp_o.hit   = 1'b1;
        rsp_o.rdata = {{(`DM_WORD_W-1){1'b0}}, halted_i};
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dmcontrol_q <= '0;
      havereset_q <= 1'b1;
    end else begin
      dmcontrol_q <= dmcontrol_d;
      havereset_q <= havereset_d;
    end
  end

endmodule

// File: verilog/dm_pkg.sv
`include "dm_settings.svh"

package dm_pkg;

  // host request, addr in the top bits
  typedef struct packed {
    logic [`DM_ADDR_W-1:0] addr;
    logic [`DM_WORD_W-1:0] data;
    logic [1:0]            op;
  } dmi_req_t;

  typedef struct packed {
    logic [`DM_WORD_W-1:0] data;
    logic [1:0]            resp;
  } dmi_resp_t;

  // what one register group has to say about the current request
  typedef struct packed {
    logic                  hit;
    logic                  busy;
    logic [`DM_WORD_W-1:0] rdata;
  } csr_rsp_t;

  typedef struct packed {
    logic       haltreq;
    logic       resumereq;
    logic       hartreset;
    logic       ackhavereset;
    logic       zero1;
    logic       hasel;
    logic [9:0] hartsello;
    logic [9:0] hartselhi;
    logic [3:0] zero0;      // no resethaltreq support
    logic       ndmreset;
    logic       dmactive;
  } dmcontrol_t;

  typedef struct packed {
    logic [2:0]                    zero3;
    logic [`DM_PROGBUFSIZE_W-1:0]  progbufsize;
    logic [10:0]                   zero2;
    logic                          busy;
    logic                          zero1;
    logic [`DM_CMDERR_W-1:0]       cmderr;
    logic [3:0]                    zero0;
    logic [`DM_DATACOUNT_W-1:0]    datacount;
  } abstractcs_t;

  // one dmi data word, meaning depends on the address
  typedef union packed {
    dmcontrol_t            dmcontrol;
    abstractcs_t           abstractcs;
    logic [`DM_WORD_W-1:0] raw;
  } csr_word_u;

endpackage

// File: verilog/dm_settings.svh
`ifndef DM_SETTINGS_SVH
`define DM_SETTINGS_SVH

`define DM_DATA_COUNT        2
`define DM_PROGBUF_SIZE      8
`define DM_ADDR_W            7
`define DM_WORD_W            32
`define DM_DATACOUNT_W       4  // abstractcs.datacount
`define DM_PROGBUFSIZE_W     5  // abstractcs.progbufsize
`define DM_CMDERR_W          3

// dmi register map
`define DM_ADDR_DATA0        7'h04
`define DM_ADDR_DMCONTROL    7'h10
`define DM_ADDR_DMSTATUS     7'h11
`define DM_ADDR_ABSTRACTCS   7'h16
`define DM_ADDR_COMMAND      7'h17
`define DM_ADDR_ABSTRACTAUTO 7'h18
`define DM_ADDR_PROGBUF0     7'h20
`define DM_ADDR_HALTSUM0     7'h40

`define DM_OP_NOP            2'h0
`define DM_OP_READ           2'h1
`define DM_OP_WRITE          2'h2
`define DM_RESP_SUCCESS      2'h0
`define DM_RESP_BUSY         2'h3
`define DM_CMDERR_NONE       3'h0
`define DM_CMDERR_BUSY       3'h1

`endif
